// ==== apf_bridge_pkg.sv ====
/*
 * host bridge bus types
 * video offset window base address and register offsets
 */

package apf_bridge_pkg;

	//////////////////////////////////////////////////
	// bus words
	//////////////////////////////////////////////////

	// byte address as the host puts it on the bridge
	typedef logic [31:0] bridge_addr_t;

	// one bridge data word, read or write
	typedef logic [31:0] bridge_data_t;

	//////////////////////////////////////////////////
	// address map
	//////////////////////////////////////////////////

	// low address bits that select a register inside a window
	localparam int WIN_LSB = 8;

	// video offset window, 0x200000xx
	localparam logic [23:0] VIDEO_WIN_BASE = 24'h200000; // compared against addr[31:8]

	// registers inside the video window, byte offsets
	localparam logic [7:0] REG_X_OFFSET = 8'h00; // horizontal picture shift
	localparam logic [7:0] REG_Y_OFFSET = 8'h04; // vertical picture shift

	// other windows on the bridge (host commands, mpu) are not decoded here
	// and read back as zero through the unmapped path

endpackage

// ==== amiga_io_pkg.sv ====
/*
 * video, pixel and offset types
 * joystick and keyboard/mouse channel types
 * resolution codes and cpu clock divider width
 */

package amiga_io_pkg;

	//////////////////////////////////////////////////
	// video
	//////////////////////////////////////////////////

	typedef logic [7:0]  color_t; // one colour channel
	typedef logic [23:0] pixel_t; // r in 23:16, g in 15:8, b in 7:0

	// picture shift in pixels / lines
	localparam int OFFSET_W = 8;
	typedef logic [OFFSET_W-1:0] offset_t;

	// chipset resolution, sent to the scaler in the hblank sideband word
	typedef enum logic [1:0] {
		res_lores = 2'd0, // all-zero sideband word
		res_hires = 2'd1,
		res_shres = 2'd2,
		res_rsvd  = 2'd3  // fourth code, passed through as is
	} res_e;

	//////////////////////////////////////////////////
	// input devices
	//////////////////////////////////////////////////

	typedef logic [31:0] cont_key_t; // dock controller key bitmap
	typedef logic [15:0] joy_t;      // amiga joystick word, 11 bits used

	// shared keyboard/mouse byte channel into the chipset
	typedef logic [7:0] km_byte_t;

	// slot names on the byte channel
	typedef enum logic [1:0] {
		km_mouse_y   = 2'd0,
		km_keyboard  = 2'd1,
		km_key_state = 2'd2,
		km_mouse_x   = 2'd3
	} km_type_e;

	//////////////////////////////////////////////////
	// cpu clocking
	//////////////////////////////////////////////////

	localparam int PHASE_DIV_W = 4; // 16 clocks per cpu cycle frame

endpackage

// ==== bridge_regs.sv ====
/*
 * video offset registers on the host bridge
 * write decode against the video window
 * registered read mux, unmapped reads give zero
 */

module bridge_regs #(
	parameter int OFFSET_W = amiga_io_pkg::OFFSET_W
) (
	input  logic                         clk_74a,
	input  logic                         cpu_rst,

	input  apf_bridge_pkg::bridge_addr_t bridge_addr,
	input  logic                         bridge_rd,
	input  logic                         bridge_wr,
	input  apf_bridge_pkg::bridge_data_t bridge_wr_data,
	output apf_bridge_pkg::bridge_data_t bridge_rd_data,

	output amiga_io_pkg::offset_t        x_offset,
	output amiga_io_pkg::offset_t        y_offset
);

	logic                         win_hit;     // address inside 0x200000xx
	logic [7:0]                   reg_sel;     // byte offset inside the window
	apf_bridge_pkg::bridge_data_t win_rd_data; // window local read value

	assign reg_sel = bridge_addr[apf_bridge_pkg::WIN_LSB-1:0];
	assign win_hit = (bridge_addr[31:apf_bridge_pkg::WIN_LSB] == apf_bridge_pkg::VIDEO_WIN_BASE);

	//////////////////////////////////////////////////
	// write decode
	//////////////////////////////////////////////////

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			x_offset <= '0;
			y_offset <= '0;
		end else if (bridge_wr && win_hit) begin
			case (reg_sel)
				apf_bridge_pkg::REG_X_OFFSET: x_offset <= bridge_wr_data[OFFSET_W-1:0];
				apf_bridge_pkg::REG_Y_OFFSET: y_offset <= bridge_wr_data[OFFSET_W-1:0];
				default: ; // holes in the window ignore writes
			endcase
		end
	end

	//////////////////////////////////////////////////
	// read path
	//////////////////////////////////////////////////

	// register select inside the window
	always_comb begin
		win_rd_data = '0;
		case (reg_sel)
			apf_bridge_pkg::REG_X_OFFSET: win_rd_data = apf_bridge_pkg::bridge_data_t'(x_offset);
			apf_bridge_pkg::REG_Y_OFFSET: win_rd_data = apf_bridge_pkg::bridge_data_t'(y_offset);
			default:                      win_rd_data = '0;
		endcase
	end

	// window mux, one register stage, holds between reads
	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			bridge_rd_data <= '0;
		end else if (bridge_rd) begin
			bridge_rd_data <= win_hit ? win_rd_data : '0; // everything else unmapped
		end
	end

endmodule

// ==== video_formatter.sv ====
/*
 * video output formatter towards the scaler
 * x/y offset counters and data enable gating
 * four stage hsync delay, vsync pulse
 * interlace and resolution sideband words on the pixel bus
 */

module video_formatter #(
	parameter int OFFSET_W = amiga_io_pkg::OFFSET_W
) (
	input  logic                  clk_74a,
	input  logic                  cpu_rst,

	// chipset video, active low syncs
	input  logic                  core_hs,
	input  logic                  core_vs,
	input  logic                  core_hblank,
	input  logic                  core_vblank,
	input  amiga_io_pkg::color_t  core_r,
	input  amiga_io_pkg::color_t  core_g,
	input  amiga_io_pkg::color_t  core_b,
	input  logic                  field1,
	input  logic                  lace,
	input  amiga_io_pkg::res_e    res,

	// picture shift from the bridge
	input  amiga_io_pkg::offset_t x_offset,
	input  amiga_io_pkg::offset_t y_offset,

	output amiga_io_pkg::pixel_t  video_rgb,
	output logic                  video_de,
	output logic                  video_skip,
	output logic                  video_vs,
	output logic                  video_hs
);

	logic hs_d, vs_d, hblank_d; // inputs one edge back, for edge detect
	logic hs_fall;
	logic vs_fall;
	logic hblank_rise;
	logic active;               // neither blank asserted
	logic [3:0] hs_dly;         // hsync delay line

	logic [OFFSET_W-1:0] x_cnt; // pixels still to hide on this line
	logic [OFFSET_W-1:0] y_cnt; // lines still to hide in this field

	amiga_io_pkg::pixel_t lace_word;
	amiga_io_pkg::pixel_t res_word;

	assign hs_fall     = hs_d & ~core_hs;
	assign vs_fall     = vs_d & ~core_vs;
	assign hblank_rise = core_hblank & ~hblank_d;
	assign active      = ~core_hblank & ~core_vblank;

	//////////////////////////////////////////////////
	// sideband words
	//////////////////////////////////////////////////

	// scaler reads bit 1 as interlaced, bit 2 as the odd field
	assign lace_word = {21'd0, field1 & lace, lace, 1'b0};

	// res code in 15:13, lores ends up all zero
	assign res_word = {8'h00, 1'b0, res, 13'd0};

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			video_rgb  <= '0;
			video_de   <= 1'b0;
			video_skip <= 1'b0;
			video_vs   <= 1'b0;
			video_hs   <= 1'b0;
			hs_d       <= 1'b0;
			vs_d       <= 1'b0;
			hblank_d   <= 1'b0;
			hs_dly     <= '0;
			x_cnt      <= '0;
			y_cnt      <= '0;
		end else begin
			video_rgb  <= '0; // blank between sideband words
			video_de   <= 1'b0;
			video_skip <= 1'b0; // every pixel is kept
			video_vs   <= 1'b0;

			hs_d     <= core_hs;
			vs_d     <= core_vs;
			hblank_d <= core_hblank;

			// hsync pulse walks four stages, then out
			hs_dly   <= {hs_dly[2:0], hs_fall};
			video_hs <= hs_dly[3];

			if (hs_fall) begin
				x_cnt <= x_offset; // restart pixel skip each line
				if (y_cnt != '0)
					y_cnt <= y_cnt - 1'b1;
			end

			// vsync edge wins over active video, active video over hblank edge
			if (vs_fall) begin
				y_cnt     <= y_offset;
				video_vs  <= 1'b1;
				video_rgb <= lace_word;
			end else if (active) begin
				video_rgb <= {core_r, core_g, core_b};
				if (x_cnt == '0 && y_cnt == '0)
					video_de <= 1'b1; // past both offsets
				if (x_cnt != '0)
					x_cnt <= x_cnt - 1'b1;
			end else if (hblank_rise) begin
				video_rgb <= res_word; // first blank cycle only
			end
		end
	end

endmodule

// ==== amiga_input_mux.sv ====
/*
 * controller to amiga joystick remap, active low words
 * keyboard / key state / mouse bytes rotated onto one byte channel
 * level bit toggles each cycle to mark a fresh byte
 */

module amiga_input_mux (
	input  logic                    clk_74a,
	input  logic                    cpu_rst,

	input  amiga_io_pkg::cont_key_t cont1_key,
	input  amiga_io_pkg::cont_key_t cont2_key,
	input  amiga_io_pkg::cont_key_t cont3_key, // low byte carries key state
	input  amiga_io_pkg::km_byte_t  amiga_keyboard,
	input  amiga_io_pkg::km_byte_t  mouse_x,
	input  amiga_io_pkg::km_byte_t  mouse_y,

	output amiga_io_pkg::joy_t      joy0_n,
	output amiga_io_pkg::joy_t      joy1_n,
	output amiga_io_pkg::km_byte_t  kbd_mouse_data,
	output amiga_io_pkg::km_type_e  kbd_mouse_type,
	output logic                    kbd_mouse_level
);

	//////////////////////////////////////////////////
	// joysticks
	//////////////////////////////////////////////////

	// dock bitmap to amiga order
	// select r1 l1 y x a b up down left right, msb first
	function automatic amiga_io_pkg::joy_t joy_remap(input amiga_io_pkg::cont_key_t key);
		joy_remap = {5'd0,
			key[14], key[9], key[8], key[7], key[6], // select, shoulders, y, x
			key[4],  key[5],                         // fire a, fire b
			key[0],  key[1], key[2], key[3]};        // dpad
	endfunction

	assign joy0_n = ~joy_remap(cont1_key); // mouse port
	assign joy1_n = ~joy_remap(cont2_key); // joystick port

	//////////////////////////////////////////////////
	// keyboard/mouse channel
	//////////////////////////////////////////////////

	// slot fsm, one step per clock, 1 -> 2 -> 3 -> 0
	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			kbd_mouse_type  <= amiga_io_pkg::km_mouse_y;
			kbd_mouse_level <= 1'b0;
		end else begin
			kbd_mouse_level <= ~kbd_mouse_level; // chipset samples on every level change
			case (kbd_mouse_type)
				amiga_io_pkg::km_keyboard:  kbd_mouse_type <= amiga_io_pkg::km_key_state;
				amiga_io_pkg::km_key_state: kbd_mouse_type <= amiga_io_pkg::km_mouse_x;
				amiga_io_pkg::km_mouse_x:   kbd_mouse_type <= amiga_io_pkg::km_mouse_y;
				default:                    kbd_mouse_type <= amiga_io_pkg::km_keyboard;
			endcase
		end
	end

	// byte loaded in step with the slot it goes with
	always_ff @(posedge clk_74a) begin
		case (kbd_mouse_type)
			amiga_io_pkg::km_keyboard:  kbd_mouse_data <= amiga_keyboard; // out with type 2
			amiga_io_pkg::km_key_state: kbd_mouse_data <= cont3_key[7:0]; // out with type 3
			amiga_io_pkg::km_mouse_x:   kbd_mouse_data <= mouse_x;        // out with type 0
			default:                    kbd_mouse_data <= mouse_y;        // out with type 1
		endcase
	end

endmodule

// ==== cpu_phase_gen.sv ====
/*
 * cpu clock enables from a free running divider
 * re-aligned on each rising c1 of the chip bus
 * ph1 / ph2 two phase enables and the bus cycle strobe
 */

module cpu_phase_gen #(
	parameter int PHASE_DIV_W = amiga_io_pkg::PHASE_DIV_W
) (
	input  logic clk_74a,
	input  logic cpu_rst,
	input  logic c1,      // chip bus phase, 7mhz class
	output logic cyc,     // one clock per four, bus cycle strobe
	output logic cpu_ph1,
	output logic cpu_ph2
);

	logic [PHASE_DIV_W-1:0] div;
	logic [PHASE_DIV_W-3:0] div_hi; // which quarter of the frame
	logic                   c1_d;
	logic                   c1_rise;

	assign c1_rise = c1 & ~c1_d;
	assign div_hi  = div[PHASE_DIV_W-1:2];

	//////////////////////////////////////////////////
	// divider
	//////////////////////////////////////////////////

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			div  <= '0;
			c1_d <= 1'b0;
		end else begin
			c1_d <= c1;
			if (c1_rise)
				div <= PHASE_DIV_W'(3); // snap to the c1 phase
			else
				div <= div + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// phase decode
	//////////////////////////////////////////////////

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			cyc     <= 1'b0;
			cpu_ph1 <= 1'b0;
			cpu_ph2 <= 1'b0;
		end else begin
			cyc <= (div[1:0] == 2'b00);
			if (div[1:0] == 2'b10) begin // phases only move here
				cpu_ph1 <= 1'b0;
				cpu_ph2 <= 1'b0;
				if (div_hi == '0)
					cpu_ph2 <= 1'b1;
				else if (div_hi == (PHASE_DIV_W-2)'(2))
					cpu_ph1 <= 1'b1; // half a frame after ph2
			end
		end
	end

endmodule

// ==== apf_core_top.sv ====
/*
 * core glue top level in the clk_74a domain
 * bridge registers, video formatter, input mux, cpu phase generator
 */

module apf_core_top #(
	parameter int OFFSET_W    = amiga_io_pkg::OFFSET_W,
	parameter int PHASE_DIV_W = amiga_io_pkg::PHASE_DIV_W
) (
	input  logic                         clk_74a,
	input  logic                         cpu_rst,

	// host bridge
	input  apf_bridge_pkg::bridge_addr_t bridge_addr,
	input  logic                         bridge_rd,
	input  logic                         bridge_wr,
	input  apf_bridge_pkg::bridge_data_t bridge_wr_data,
	output apf_bridge_pkg::bridge_data_t bridge_rd_data,

	// chipset video in
	input  logic                         core_hs,
	input  logic                         core_vs,
	input  logic                         core_hblank,
	input  logic                         core_vblank,
	input  amiga_io_pkg::color_t         core_r,
	input  amiga_io_pkg::color_t         core_g,
	input  amiga_io_pkg::color_t         core_b,
	input  logic                         field1,
	input  logic                         lace,
	input  amiga_io_pkg::res_e           res,

	// controllers, keyboard, mouse
	input  amiga_io_pkg::cont_key_t      cont1_key,
	input  amiga_io_pkg::cont_key_t      cont2_key,
	input  amiga_io_pkg::cont_key_t      cont3_key,
	input  amiga_io_pkg::km_byte_t       amiga_keyboard,
	input  amiga_io_pkg::km_byte_t       mouse_x,
	input  amiga_io_pkg::km_byte_t       mouse_y,

	input  logic                         c1,

	// scaler video out
	output amiga_io_pkg::pixel_t         video_rgb,
	output logic                         video_de,
	output logic                         video_skip,
	output logic                         video_vs,
	output logic                         video_hs,

	// to the chipset
	output amiga_io_pkg::joy_t           joy0_n,
	output amiga_io_pkg::joy_t           joy1_n,
	output amiga_io_pkg::km_byte_t       kbd_mouse_data,
	output amiga_io_pkg::km_type_e       kbd_mouse_type,
	output logic                         kbd_mouse_level,

	// to the cpu
	output logic                         cyc,
	output logic                         cpu_ph1,
	output logic                         cpu_ph2
);

	amiga_io_pkg::offset_t x_offset; // bridge -> formatter
	amiga_io_pkg::offset_t y_offset;

	//////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////

	bridge_regs #(
		.OFFSET_W (OFFSET_W)
	) u_bridge_regs (
		.clk_74a        (clk_74a),
		.cpu_rst        (cpu_rst),
		.bridge_addr    (bridge_addr),
		.bridge_rd      (bridge_rd),
		.bridge_wr      (bridge_wr),
		.bridge_wr_data (bridge_wr_data),
		.bridge_rd_data (bridge_rd_data),
		.x_offset       (x_offset),
		.y_offset       (y_offset)
	);

	video_formatter #(
		.OFFSET_W (OFFSET_W)
	) u_video_formatter (
		.clk_74a     (clk_74a),
		.cpu_rst     (cpu_rst),
		.core_hs     (core_hs),
		.core_vs     (core_vs),
		.core_hblank (core_hblank),
		.core_vblank (core_vblank),
		.core_r      (core_r),
		.core_g      (core_g),
		.core_b      (core_b),
		.field1      (field1),
		.lace        (lace),
		.res         (res),
		.x_offset    (x_offset),
		.y_offset    (y_offset),
		.video_rgb   (video_rgb),
		.video_de    (video_de),
		.video_skip  (video_skip),
		.video_vs    (video_vs),
		.video_hs    (video_hs)
	);

	amiga_input_mux u_amiga_input_mux (
		.clk_74a         (clk_74a),
		.cpu_rst         (cpu_rst),
		.cont1_key       (cont1_key),
		.cont2_key       (cont2_key),
		.cont3_key       (cont3_key),
		.amiga_keyboard  (amiga_keyboard),
		.mouse_x         (mouse_x),
		.mouse_y         (mouse_y),
		.joy0_n          (joy0_n),
		.joy1_n          (joy1_n),
		.kbd_mouse_data  (kbd_mouse_data),
		.kbd_mouse_type  (kbd_mouse_type),
		.kbd_mouse_level (kbd_mouse_level)
	);

	cpu_phase_gen #(
		.PHASE_DIV_W (PHASE_DIV_W)
	) u_cpu_phase_gen (
		.clk_74a (clk_74a),
		.cpu_rst (cpu_rst),
		.c1      (c1),
		.cyc     (cyc),
		.cpu_ph1 (cpu_ph1),
		.cpu_ph2 (cpu_ph2)
	);

endmodule

// ==== apf_core_chk.sv ====
/*
 * concurrent assertions bound into the core top level
 * bridge regs, de gating, syncs, sideband words, input mux, cpu phases
 */

module apf_core_chk #(
	parameter int ACTIVE_PIX = 20 // active pixels per line in the stimulus
) (
	input logic                         clk_74a,
	input logic                         cpu_rst,
	input apf_bridge_pkg::bridge_addr_t bridge_addr,
	input logic                         bridge_rd,
	input logic                         bridge_wr,
	input apf_bridge_pkg::bridge_data_t bridge_wr_data,
	input apf_bridge_pkg::bridge_data_t bridge_rd_data,
	input logic                         core_hs,
	input logic                         core_vs,
	input logic                         core_hblank,
	input logic                         core_vblank,
	input amiga_io_pkg::color_t         core_r,
	input amiga_io_pkg::color_t         core_g,
	input amiga_io_pkg::color_t         core_b,
	input logic                         field1,
	input logic                         lace,
	input amiga_io_pkg::res_e           res,
	input amiga_io_pkg::offset_t        x_offset,
	input amiga_io_pkg::offset_t        y_offset,
	input amiga_io_pkg::offset_t        x_cnt,
	input amiga_io_pkg::offset_t        y_cnt,
	input amiga_io_pkg::pixel_t         video_rgb,
	input logic                         video_de,
	input logic                         video_skip,
	input logic                         video_vs,
	input logic                         video_hs,
	input amiga_io_pkg::cont_key_t      cont1_key,
	input amiga_io_pkg::cont_key_t      cont2_key,
	input amiga_io_pkg::cont_key_t      cont3_key,
	input amiga_io_pkg::km_byte_t       amiga_keyboard,
	input amiga_io_pkg::km_byte_t       mouse_x,
	input amiga_io_pkg::km_byte_t       mouse_y,
	input amiga_io_pkg::joy_t           joy0_n,
	input amiga_io_pkg::joy_t           joy1_n,
	input amiga_io_pkg::km_byte_t       kbd_mouse_data,
	input amiga_io_pkg::km_type_e       kbd_mouse_type,
	input logic                         kbd_mouse_level,
	input logic                         cyc,
	input logic                         cpu_ph1,
	input logic                         cpu_ph2
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam apf_bridge_pkg::bridge_addr_t ADDR_X =
		{apf_bridge_pkg::VIDEO_WIN_BASE, apf_bridge_pkg::REG_X_OFFSET};
	localparam apf_bridge_pkg::bridge_addr_t ADDR_Y =
		{apf_bridge_pkg::VIDEO_WIN_BASE, apf_bridge_pkg::REG_Y_OFFSET};

	// dock key bit positions
	localparam int K_UP    = 0;
	localparam int K_DOWN  = 1;
	localparam int K_LEFT  = 2;
	localparam int K_RIGHT = 3;
	localparam int K_A     = 4;
	localparam int K_B     = 5;
	localparam int K_X     = 6;
	localparam int K_Y     = 7;
	localparam int K_L1    = 8;
	localparam int K_R1    = 9;
	localparam int K_SEL   = 14;

	int         fail_cnt = 0; // read by the testbench
	logic [7:0] x_shadow, y_shadow; // last written low bytes
	logic       hs_q, vs_q, hb_q;
	int         line_no;      // lines since vsync fall
	int         de_acc;       // de cycles on the current line
	int         exp_de;
	int         warm;         // cycles since reset while the phase locks
	logic       hb_rise;

	function automatic amiga_io_pkg::joy_t joy_expect(input amiga_io_pkg::cont_key_t k);
		amiga_io_pkg::joy_t j;
		j = '0;
		j[10] = k[K_SEL];
		j[9]  = k[K_R1];
		j[8]  = k[K_L1];
		j[7]  = k[K_Y];
		j[6]  = k[K_X];
		j[5]  = k[K_A];
		j[4]  = k[K_B];
		j[3]  = k[K_UP];
		j[2]  = k[K_DOWN];
		j[1]  = k[K_LEFT];
		j[0]  = k[K_RIGHT];
		return ~j; // active low with unused bits high
	endfunction

	assign hb_rise = core_hblank & ~hb_q;
	// hidden lines first and then hidden pixels of each line
	assign exp_de = (line_no < int'(y_offset)) ? 0 :
		(int'(x_offset) >= ACTIVE_PIX) ? 0 : ACTIVE_PIX - int'(x_offset);

	//////////////////////////////////////////////////
	// reference state
	//////////////////////////////////////////////////

	always_ff @(posedge clk_74a) begin
		if (!cpu_rst) begin
			x_shadow <= '0;
			y_shadow <= '0;
			hs_q     <= 1'b1;
			vs_q     <= 1'b1;
			hb_q     <= 1'b0;
			line_no  <= 0;
			de_acc   <= 0;
			warm     <= 0;
		end else begin
			hs_q <= core_hs;
			vs_q <= core_vs;
			hb_q <= core_hblank;
			if (warm < 64)
				warm <= warm + 1;
			if (bridge_wr && bridge_addr == ADDR_X)
				x_shadow <= bridge_wr_data[7:0];
			if (bridge_wr && bridge_addr == ADDR_Y)
				y_shadow <= bridge_wr_data[7:0];
			if (vs_q && !core_vs)
				line_no <= 0;
			else if (hs_q && !core_hs)
				line_no <= line_no + 1;
			de_acc <= hb_rise ? 0 : de_acc + int'(video_de);
		end
	end

	//////////////////////////////////////////////////
	// bridge
	//////////////////////////////////////////////////

	a_rd_x: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		bridge_rd && bridge_addr == ADDR_X |=> bridge_rd_data == 32'($past(x_shadow)))
		else begin fail_cnt++; $error("MISMATCH %0t: x_offset read back", $time); end
	a_rd_y: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		bridge_rd && bridge_addr == ADDR_Y |=> bridge_rd_data == 32'($past(y_shadow)))
		else begin fail_cnt++; $error("MISMATCH %0t: y_offset read back", $time); end
	a_rd_unmapped: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		bridge_rd && bridge_addr != ADDR_X && bridge_addr != ADDR_Y |=> bridge_rd_data == '0)
		else begin fail_cnt++; $error("MISMATCH %0t: unmapped read not zero", $time); end

	//////////////////////////////////////////////////
	// video
	//////////////////////////////////////////////////

	a_de_gate: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		video_de |-> $past(x_cnt == '0 && y_cnt == '0))
		else begin fail_cnt++; $error("MISMATCH %0t: de inside offset area", $time); end
	a_de_count: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		hb_rise && !core_vblank |-> de_acc + int'(video_de) == exp_de)
		else begin fail_cnt++; $error("MISMATCH %0t: de count on line %0d", $time, line_no); end
	a_pixel: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		!core_hblank && !core_vblank && !$fell(core_vs) |=>
			video_rgb == $past({core_r, core_g, core_b}))
		else begin fail_cnt++; $error("MISMATCH %0t: active pixel", $time); end
	a_skip: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		!video_skip)
		else begin fail_cnt++; $error("MISMATCH %0t: video_skip set", $time); end
	a_hs_delay: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		$fell(core_hs) |-> ##4 !video_hs ##1 video_hs ##1 !video_hs)
		else begin fail_cnt++; $error("MISMATCH %0t: hsync delay", $time); end
	a_vs_word: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		$fell(core_vs) |=> video_vs
			&& video_rgb == amiga_io_pkg::pixel_t'({$past(field1 & lace), $past(lace), 1'b0})
			##1 !video_vs)
		else begin fail_cnt++; $error("MISMATCH %0t: vsync pulse or lace word", $time); end
	a_res_word: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		$rose(core_hblank) && !core_vblank |=>
			video_rgb == amiga_io_pkg::pixel_t'({$past(res), 13'd0}))
		else begin fail_cnt++; $error("MISMATCH %0t: resolution word", $time); end

	//////////////////////////////////////////////////
	// inputs
	//////////////////////////////////////////////////

	a_level: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		$past(cpu_rst) |-> kbd_mouse_level != $past(kbd_mouse_level))
		else begin fail_cnt++; $error("MISMATCH %0t: level did not toggle", $time); end
	a_slot_order: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		$past(cpu_rst) |-> kbd_mouse_type == amiga_io_pkg::km_type_e'($past(kbd_mouse_type) + 2'd1))
		else begin fail_cnt++; $error("MISMATCH %0t: slot order", $time); end
	a_slot_data: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		$past(cpu_rst) |-> kbd_mouse_data ==
			(kbd_mouse_type == amiga_io_pkg::km_key_state ? $past(amiga_keyboard) :
			 kbd_mouse_type == amiga_io_pkg::km_mouse_x   ? $past(cont3_key[7:0]) :
			 kbd_mouse_type == amiga_io_pkg::km_mouse_y   ? $past(mouse_x) : $past(mouse_y)))
		else begin fail_cnt++; $error("MISMATCH %0t: channel byte", $time); end
	a_joy0: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		joy0_n == joy_expect(cont1_key))
		else begin fail_cnt++; $error("MISMATCH %0t: joy0 remap", $time); end
	a_joy1: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		joy1_n == joy_expect(cont2_key))
		else begin fail_cnt++; $error("MISMATCH %0t: joy1 remap", $time); end

	//////////////////////////////////////////////////
	// cpu phases
	//////////////////////////////////////////////////

	a_cyc: assert property (@(posedge clk_74a) disable iff (!cpu_rst || warm < 40)
		cyc |=> !cyc [*3] ##1 cyc)
		else begin fail_cnt++; $error("MISMATCH %0t: cyc period", $time); end
	a_ph_seq: assert property (@(posedge clk_74a) disable iff (!cpu_rst || warm < 40)
		$rose(cpu_ph2) |-> cpu_ph2 [*4] ##1 (!cpu_ph2 && !cpu_ph1) [*4]
			##1 cpu_ph1 [*4] ##1 !cpu_ph1)
		else begin fail_cnt++; $error("MISMATCH %0t: ph1/ph2 sequence", $time); end
	a_ph_excl: assert property (@(posedge clk_74a) disable iff (!cpu_rst)
		!(cpu_ph1 && cpu_ph2))
		else begin fail_cnt++; $error("MISMATCH %0t: ph1 and ph2 both high", $time); end

endmodule

bind apf_core_top apf_core_chk #(.ACTIVE_PIX(20)) u_chk (
	.*,
	.x_cnt (u_video_formatter.x_cnt),
	.y_cnt (u_video_formatter.y_cnt)
);

// ==== tb_apf_core.sv ====
/*
 * testbench for the core glue top level
 * clock, reset, bridge traffic, synthetic frames, random inputs
 */

module tb_apf_core;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 10;
	localparam int RST_CYCLES = 8;
	localparam int ACTIVE_PIX = 20;
	localparam int LINES      = 8;
	localparam int FRAMES     = 6;
	// about 250 cycles a frame plus bridge traffic and margin
	localparam int MAX_CYCLES = 4000;
	localparam apf_bridge_pkg::bridge_addr_t ADDR_X = 32'h2000_0000;
	localparam apf_bridge_pkg::bridge_addr_t ADDR_Y = 32'h2000_0004;

	logic clk_74a = 1'b0;
	logic cpu_rst;
	apf_bridge_pkg::bridge_addr_t bridge_addr;
	logic bridge_rd, bridge_wr;
	apf_bridge_pkg::bridge_data_t bridge_wr_data, bridge_rd_data;
	logic core_hs, core_vs, core_hblank, core_vblank;
	amiga_io_pkg::color_t core_r, core_g, core_b;
	logic field1, lace;
	amiga_io_pkg::res_e res;
	amiga_io_pkg::cont_key_t cont1_key, cont2_key, cont3_key;
	amiga_io_pkg::km_byte_t amiga_keyboard, mouse_x, mouse_y;
	logic c1;
	amiga_io_pkg::pixel_t video_rgb;
	logic video_de, video_skip, video_vs, video_hs;
	amiga_io_pkg::joy_t joy0_n, joy1_n;
	amiga_io_pkg::km_byte_t kbd_mouse_data;
	amiga_io_pkg::km_type_e kbd_mouse_type;
	logic kbd_mouse_level, cyc, cpu_ph1, cpu_ph2;

	int cycle_cnt = 0;
	logic rand_en = 1'b0;
	int x_list[FRAMES] = '{0, 3, 7, 20, 12, 5};
	int y_list[FRAMES] = '{0, 2, 1, 3, 8, 5};

	apf_core_top u_apf_core_top (.*);

	always #(CLK_PERIOD/2) clk_74a = ~clk_74a;

	// chip bus phase of 16 clocks
	always begin
		repeat (8) @(negedge clk_74a);
		c1 = ~c1;
	end

	// controllers and byte sources change every cycle
	always @(negedge clk_74a) begin
		if (rand_en) begin
			cont1_key      = $urandom;
			cont2_key      = $urandom;
			cont3_key      = $urandom;
			amiga_keyboard = 8'($urandom);
			mouse_x        = 8'($urandom);
			mouse_y        = 8'($urandom);
		end
	end

	// run limit
	always @(posedge clk_74a) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == MAX_CYCLES) begin
			$display("run timed out after %0d cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// bus and video tasks
	//////////////////////////////////////////////////

	task automatic bus_write(input apf_bridge_pkg::bridge_addr_t a, input logic [31:0] d);
		@(negedge clk_74a);
		bridge_addr    = a;
		bridge_wr_data = d;
		bridge_wr      = 1'b1;
		@(negedge clk_74a);
		bridge_wr      = 1'b0;
	endtask

	task automatic bus_read(input apf_bridge_pkg::bridge_addr_t a);
		@(negedge clk_74a);
		bridge_addr = a;
		bridge_rd   = 1'b1;
		@(negedge clk_74a);
		bridge_rd   = 1'b0;
	endtask

	task automatic video_step(input logic hs, input logic vs, input logic hb, input logic vb);
		@(negedge clk_74a);
		core_hs     = hs;
		core_vs     = vs;
		core_hblank = hb;
		core_vblank = vb;
		core_r      = hb ? 8'h00 : 8'($urandom);
		core_g      = hb ? 8'h00 : 8'($urandom);
		core_b      = hb ? 8'h00 : 8'($urandom);
	endtask

	task automatic run_frame(input int xo, input int yo);
		bus_write(ADDR_X, 32'(xo));
		bus_write(ADDR_Y, 32'(yo));
		field1 = 1'($urandom);
		lace   = 1'($urandom);
		res    = amiga_io_pkg::res_e'(2'($urandom));
		repeat (2) video_step(1'b1, 1'b0, 1'b1, 1'b1); // vsync
		repeat (2) video_step(1'b1, 1'b1, 1'b1, 1'b1);
		for (int l = 0; l < LINES; l++) begin
			repeat (2) video_step(1'b0, 1'b1, 1'b1, 1'b0);
			repeat (2) video_step(1'b1, 1'b1, 1'b1, 1'b0);
			repeat (ACTIVE_PIX) video_step(1'b1, 1'b1, 1'b0, 1'b0);
			repeat (3) video_step(1'b1, 1'b1, 1'b1, 1'b0); // hblank rise
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int fails;
		void'($urandom(31));
		cpu_rst        = 1'b0;
		bridge_addr    = '0;
		bridge_rd      = 1'b0;
		bridge_wr      = 1'b0;
		bridge_wr_data = '0;
		core_hs        = 1'b1;
		core_vs        = 1'b1;
		core_hblank    = 1'b1;
		core_vblank    = 1'b1;
		core_r         = '0;
		core_g         = '0;
		core_b         = '0;
		field1         = 1'b0;
		lace           = 1'b0;
		res            = amiga_io_pkg::res_lores;
		cont1_key      = '0;
		cont2_key      = '0;
		cont3_key      = '0;
		amiga_keyboard = '0;
		mouse_x        = '0;
		mouse_y        = '0;
		c1             = 1'b0;
		repeat (RST_CYCLES) @(negedge clk_74a);
		cpu_rst = 1'b1;
		rand_en = 1'b1;

		// bridge window registers, a hole and foreign windows
		bus_read(ADDR_X);
		bus_write(ADDR_X, 32'hdead_bea5);
		bus_write(ADDR_Y, 32'h0000_013c);
		bus_write(32'h4000_0000, 32'h77); // outside the window
		bus_read(ADDR_X);
		bus_read(ADDR_Y);
		bus_read(32'h2000_0008);
		bus_read(32'h3000_0000);
		bus_read(32'h2000_0104);

		for (int f = 0; f < FRAMES; f++)
			run_frame(x_list[f], y_list[f]);
		repeat (40) @(negedge clk_74a);

		fails = u_apf_core_top.u_chk.fail_cnt;
		$display("error count: %0d assertion failures", fails);
		if (fails == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== compile.f ====
apf_bridge_pkg.sv
amiga_io_pkg.sv
bridge_regs.sv
video_formatter.sv
amiga_input_mux.sv
cpu_phase_gen.sv
apf_core_top.sv
apf_core_chk.sv
tb_apf_core.sv

// ==== Bender.yml ====
package:
  name: apf_core

sources:
  - apf_bridge_pkg.sv
  - amiga_io_pkg.sv
  - bridge_regs.sv
  - video_formatter.sv
  - amiga_input_mux.sv
  - cpu_phase_gen.sv
  - apf_core_top.sv
  - target: simulation
    files:
      - apf_core_chk.sv
      - tb_apf_core.sv
